//--- rtl/avalon_bridge.sv
`timescale 1ns/10ps

// avalon-mm master driven by MCU register strobes
// a load of the write-data reg starts a write, a read of it starts a read
module avalon_bridge import mcu_io_pkg::*; (
    input  logic        sysclk,
    input  logic        rst,
    input  logic        wr_start,        // load strobe of the write-data reg
    input  logic        rd_start,        // read strobe of the write-data reg
    input  logic [31:0] address,         // {ad_hi, ad_lo}
    input  word_t       writedata,
    output av_cmd_t     av_cmd,
    input  logic        av_waitrequest,
    output logic        read_capture,    // loads the read-data reg
    output logic        mcu_wait         // stalls the MCU
);

    logic wr_q;   // write pending on the bus
    logic rd_q;   // read pending on the bus
    logic wr_end; // slave accepted the write this cycle

    assign wr_end = wr_q && !av_waitrequest;

    // slave returns read data in the first cycle without waitrequest
    assign read_capture = rd_q && !av_waitrequest;

    // one flag update per cycle, priority:
    // end of write, start of write, end of read, start of read
    always_ff @(posedge sysclk) begin
        if (rst) begin
            wr_q <= 1'b0;
            rd_q <= 1'b0;
        end else if (wr_end) begin
            wr_q <= 1'b0;  // write done
        end else if (wr_start) begin
            wr_q <= 1'b1;  // begin write
        end else if (read_capture) begin
            rd_q <= 1'b0;  // read done, data lands in the reg at this edge
        end else if (rd_start) begin
            rd_q <= 1'b1;  // begin read
        end
    end

    // address and data come straight from the bank regs
    // MCU is stalled meanwhile so they hold still under back-pressure
    assign av_cmd.address   = address;
    assign av_cmd.writedata = writedata;
    assign av_cmd.read      = rd_q;
    assign av_cmd.write     = wr_q;

    // capture cycle lies inside rd_q, so the read-data load is covered too
    assign mcu_wait = wr_q || rd_q;

endmodule

//--- rtl/mcu_io_pkg.sv
package mcu_io_pkg;

    // basic MCU data types
    typedef logic [15:0] word_t;  // one MCU data word
    typedef logic [7:0]  byte_t;  // uart or led payload

    // register map
    localparam int NUM_GP          = 4;   // general purpose regs at 0..3
    localparam int R_RSTK          = 4;   // return stack, push on load, pop on read
    localparam int R_LEDS          = 5;
    localparam int R_KEYS          = 6;   // inverted key inputs, read only
    localparam int R_ATX_DATA      = 7;   // write tx byte, read last rx byte
    localparam int R_ATX_CTRL      = 8;   // {rx_busy, tx_busy, go}
    localparam int R_AV_AD_HI      = 9;
    localparam int R_AV_AD_LO      = 10;
    localparam int R_AV_WRITE_DATA = 11;  // access here kicks off the avalon transfer
    localparam int R_AV_READ_DATA  = 12;
    localparam int NUM_REGS        = 13;

    // one strobe bit per register
    typedef logic [NUM_REGS-1:0] reg_sel_t;

    // requests from the MCU into the register bank
    typedef struct packed {
        reg_sel_t load;       // write load_data into the selected reg
        reg_sel_t read;       // MCU reads the selected reg this cycle
        word_t    load_data;  // shared by all registers
    } regbus_t;

    // all register values, seen by the MCU in parallel
    typedef word_t [NUM_REGS-1:0] reg_file_t;

    // avalon-mm master request
    typedef struct packed {
        logic [31:0] address;    // {ad_hi, ad_lo}
        word_t       writedata;
        logic        read;
        logic        write;
    } av_cmd_t;

    // uart timing, all on sysclk
    localparam int SAMPLE_DIV      = 4;  // sysclk cycles per sample tick
    localparam int SAMPLES_PER_BIT = 4;  // sample ticks per bit, 16 sysclk per bit
    localparam int FRAME_BITS      = 10; // start + 8 data + stop

    // counter widths derived from the timing above
    localparam int DIV_W   = $clog2(SAMPLE_DIV);
    localparam int SPB_W   = $clog2(SAMPLES_PER_BIT);
    localparam int FRAME_W = $clog2(FRAME_BITS);

    // return stack size used at the top
    localparam int RSTK_DEPTH = 32;

endpackage

//--- rtl/mcu_io_top.sv
`timescale 1ns/10ps

// peripheral side of the MCU system
// register bank plus stack, leds, keys, uart and avalon master
module mcu_io_top import mcu_io_pkg::*; (
    input  logic           sysclk,
    input  logic           rst,
    input  regbus_t        bus,             // strobes and load data from the MCU
    output wire reg_file_t r,               // every register, visible in parallel
    output logic           mcu_wait,        // stall while avalon is busy
    input  logic [1:0]     keys,            // active low buttons
    output byte_t          leds,            // active high
    output logic           tx_line,
    input  logic           rx_line,
    output av_cmd_t        av_cmd,
    input  logic           av_waitrequest,
    input  word_t          av_readdata
);

    byte_t tx_byte;       // byte queued for the transmitter
    logic  go;            // ctrl bit 0, starts tx while high
    logic  tx_busy;
    byte_t rx_byte;
    logic  rx_busy;
    logic  read_capture;  // avalon read data valid this cycle

    // general purpose registers
    for (genvar i = 0; i < NUM_GP; i++) begin : g_gp
        std_reg gp_reg (
            .sysclk (sysclk),
            .rst    (rst),
            .q      (r[i]),
            .d      (bus.load_data),
            .load   (bus.load[i])
        );
    end

    // return stack, MCU read pops
    stack_reg #(.DEPTH(RSTK_DEPTH)) rstk (
        .sysclk    (sysclk),
        .rst       (rst),
        .top       (r[R_RSTK]),
        .push_data (bus.load_data),
        .push      (bus.load[R_RSTK]),
        .pop       (bus.read[R_RSTK])
    );

    // leds
    std_reg #(.T(byte_t)) led_reg (
        .sysclk (sysclk),
        .rst    (rst),
        .q      (leds),
        .d      (bus.load_data[7:0]),
        .load   (bus.load[R_LEDS])
    );
    assign r[R_LEDS] = {8'h00, leds};

    assign r[R_KEYS] = {14'h0000, ~keys};  // 1 = pressed

    // uart data and control
    std_reg #(.T(byte_t)) atx_data_reg (
        .sysclk (sysclk),
        .rst    (rst),
        .q      (tx_byte),
        .d      (bus.load_data[7:0]),
        .load   (bus.load[R_ATX_DATA])
    );
    std_reg #(.T(logic)) atx_go_reg (
        .sysclk (sysclk),
        .rst    (rst),
        .q      (go),
        .d      (bus.load_data[0]),
        .load   (bus.load[R_ATX_CTRL])
    );
    assign r[R_ATX_DATA] = {8'h00, rx_byte};  // reads back the receiver, not tx_byte
    assign r[R_ATX_CTRL] = {13'h0000, rx_busy, tx_busy, go};

    uart_tx utx (
        .sysclk  (sysclk),
        .rst     (rst),
        .tx_data (tx_byte),
        .start   (go),  // program sets go then clears it
        .tx_line (tx_line),
        .tx_busy (tx_busy)
    );

    uart_rx urx (
        .sysclk  (sysclk),
        .rst     (rst),
        .rx_line (rx_line),
        .rx_data (rx_byte),
        .rx_busy (rx_busy)
    );

    // avalon address and data regs
    // write data is accessed last since that triggers the transfer
    std_reg av_ad_hi_reg (
        .sysclk (sysclk),
        .rst    (rst),
        .q      (r[R_AV_AD_HI]),
        .d      (bus.load_data),
        .load   (bus.load[R_AV_AD_HI])
    );
    std_reg av_ad_lo_reg (
        .sysclk (sysclk),
        .rst    (rst),
        .q      (r[R_AV_AD_LO]),
        .d      (bus.load_data),
        .load   (bus.load[R_AV_AD_LO])
    );
    std_reg av_write_data_reg (
        .sysclk (sysclk),
        .rst    (rst),
        .q      (r[R_AV_WRITE_DATA]),
        .d      (bus.load_data),
        .load   (bus.load[R_AV_WRITE_DATA])
    );
    std_reg av_read_data_reg (
        .sysclk (sysclk),
        .rst    (rst),
        .q      (r[R_AV_READ_DATA]),
        .d      (av_readdata),
        .load   (read_capture)  // visible the cycle after capture
    );

    avalon_bridge av_master (
        .sysclk         (sysclk),
        .rst            (rst),
        .wr_start       (bus.load[R_AV_WRITE_DATA]),
        .rd_start       (bus.read[R_AV_WRITE_DATA]),
        .address        ({r[R_AV_AD_HI], r[R_AV_AD_LO]}),
        .writedata      (r[R_AV_WRITE_DATA]),
        .av_cmd         (av_cmd),
        .av_waitrequest (av_waitrequest),
        .read_capture   (read_capture),
        .mcu_wait       (mcu_wait)
    );

endmodule

//--- rtl/stack_reg.sv
`timescale 1ns/10ps

// lifo register for the return stack
// load pushes, read pops, top always shows newest entry
module stack_reg import mcu_io_pkg::*; #(
    parameter int DEPTH = 32  // power of two so the pointer wraps cleanly
) (
    input  logic  sysclk,
    input  logic  rst,
    output word_t top,
    input  word_t push_data,
    input  logic  push,
    input  logic  pop
);

    word_t                    mem [DEPTH];  // stack storage
    logic [$clog2(DEPTH)-1:0] sp;           // next free slot
    logic [$clog2(DEPTH)-1:0] top_idx;      // newest entry
    logic [$clog2(DEPTH):0]   fill;         // entries held, saturates at DEPTH
    logic                     empty;
    logic                     do_pop;       // pop that actually removes something

    assign top_idx = sp - 1'b1;
    assign empty   = (fill == '0);
    assign do_pop  = pop && !empty;  // popping an empty stack is ignored
    assign top     = empty ? '0 : mem[top_idx];

    // pointer and fill level
    always_ff @(posedge sysclk) begin
        if (rst) begin
            sp   <= '0;
            fill <= '0;
        end else if (push && !do_pop) begin
            sp <= sp + 1'b1;  // wraps on overflow, oldest entry is overwritten
            if (int'(fill) < DEPTH)
                fill <= fill + 1'b1;
        end else if (do_pop && !push) begin
            sp   <= top_idx;
            fill <= fill - 1'b1;
        end
        // push with pop just replaces the top, pointer stays put
    end

    // storage
    always_ff @(posedge sysclk) begin
        if (push) begin
            if (do_pop)
                mem[top_idx] <= push_data;  // swap top in place
            else
                mem[sp] <= push_data;
        end
    end

endmodule

//--- rtl/std_reg.sv
`timescale 1ns/10ps

// plain load-enabled register, payload type picked per instance
module std_reg import mcu_io_pkg::*; #(
    parameter type T = word_t  // word, byte or single bit
) (
    input  logic sysclk,
    input  logic rst,
    output T     q,
    input  T     d,
    input  logic load
);

    always_ff @(posedge sysclk) begin
        if (rst) begin
            q <= '0;  // every register comes up zero
        end else if (load) begin
            q <= d;   // take the new value on the strobe
        end
    end

endmodule

//--- rtl/uart_rx.sv
`timescale 1ns/10ps

// 8N1 receiver, 4x oversampled on sysclk
// tick phase restarts on the start edge so samples fall mid-bit
module uart_rx import mcu_io_pkg::*; (
    input  logic  sysclk,
    input  logic  rst,
    input  logic  rx_line,
    output byte_t rx_data,   // last good byte, held
    output logic  rx_busy
);

    logic               rx_meta;  // first sync stage
    logic               rx_sync;  // safe to use
    logic               rx_prev;  // for edge detect
    logic               busy_q;
    logic [DIV_W-1:0]   div_cnt;
    logic [SPB_W-1:0]   smp_cnt;
    logic [FRAME_W-1:0] bit_cnt;  // 0 = start bit, FRAME_BITS-1 = stop bit
    byte_t              shift_q;
    byte_t              data_q;
    logic               tick;
    logic               mid_bit;
    logic               start_edge;
    logic               is_start;
    logic               is_stop;

    assign tick       = (div_cnt == DIV_W'(SAMPLE_DIV - 1));
    assign mid_bit    = tick && (smp_cnt == SPB_W'(SAMPLES_PER_BIT / 2 - 1));
    assign start_edge = rx_prev && !rx_sync;  // falling edge
    assign is_start   = (bit_cnt == '0);
    assign is_stop    = (bit_cnt == FRAME_W'(FRAME_BITS - 1));

    // 2-flop synchronizer, preset high to match the idle line
    always_ff @(posedge sysclk) begin
        if (rst) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
            rx_prev <= 1'b1;
        end else begin
            rx_meta <= rx_line;
            rx_sync <= rx_meta;
            rx_prev <= rx_sync;
        end
    end

    always_ff @(posedge sysclk) begin
        if (rst) begin
            busy_q  <= 1'b0;
            div_cnt <= '0;
            smp_cnt <= '0;
            bit_cnt <= '0;
            data_q  <= '0;
        end else if (!busy_q) begin
            if (start_edge) begin
                busy_q  <= 1'b1;
                div_cnt <= '0;  // align tick phase to the edge
                smp_cnt <= '0;
                bit_cnt <= '0;
            end
        end else begin
            div_cnt <= tick ? '0 : div_cnt + 1'b1;
            if (tick)
                smp_cnt <= smp_cnt + 1'b1;  // wraps every bit
            if (mid_bit) begin
                bit_cnt <= bit_cnt + 1'b1;
                if (is_start && rx_sync)
                    busy_q <= 1'b0;  // glitch, not a real start bit
                if (is_stop) begin
                    busy_q <= 1'b0;
                    if (rx_sync)
                        data_q <= shift_q;  // framing ok, publish byte
                end
            end
        end
    end

    // data bits arrive lsb first, shift in from the top
    always_ff @(posedge sysclk) begin
        if (busy_q && mid_bit && !is_start && !is_stop)
            shift_q <= {rx_sync, shift_q[7:1]};
    end

    assign rx_data = data_q;
    assign rx_busy = busy_q;

endmodule

//--- rtl/uart_tx.sv
`timescale 1ns/10ps

// 8N1 transmitter on sysclk with a divided sample tick
// starts whenever start is high while idle
module uart_tx import mcu_io_pkg::*; (
    input  logic  sysclk,
    input  logic  rst,
    input  byte_t tx_data,
    input  logic  start,    // level, not a pulse
    output logic  tx_line,
    output logic  tx_busy
);

    logic                  busy_q;
    logic [DIV_W-1:0]      div_cnt;  // sysclk count within a sample tick
    logic [SPB_W-1:0]      smp_cnt;  // sample ticks within a bit
    logic [FRAME_W-1:0]    bit_cnt;  // bits sent so far
    logic [FRAME_BITS-1:0] shift_q;  // lsb is on the line
    logic                  tick;
    logic                  bit_end;

    assign tick    = (div_cnt == DIV_W'(SAMPLE_DIV - 1));
    assign bit_end = tick && (smp_cnt == SPB_W'(SAMPLES_PER_BIT - 1));

    always_ff @(posedge sysclk) begin
        if (rst) begin
            busy_q  <= 1'b0;
            div_cnt <= '0;
            smp_cnt <= '0;
            bit_cnt <= '0;
            shift_q <= '1;  // line idles high
        end else if (!busy_q) begin
            if (start) begin
                busy_q  <= 1'b1;
                shift_q <= {1'b1, tx_data, 1'b0};  // stop, data lsb first, start
                div_cnt <= '0;  // fresh tick phase for each frame
                smp_cnt <= '0;
                bit_cnt <= '0;
            end
        end else begin
            div_cnt <= tick ? '0 : div_cnt + 1'b1;
            if (tick)
                smp_cnt <= bit_end ? '0 : smp_cnt + 1'b1;
            if (bit_end) begin
                shift_q <= {1'b1, shift_q[FRAME_BITS-1:1]};  // ones fill in behind
                bit_cnt <= bit_cnt + 1'b1;
                if (bit_cnt == FRAME_W'(FRAME_BITS - 1))
                    busy_q <= 1'b0;  // stop bit finished
            end
        end
    end

    assign tx_line = shift_q[0];
    assign tx_busy = busy_q;

endmodule

//--- sim/mcu_io_top_asserts.sv
`timescale 1ns/10ps

// protocol checks on the avalon master and the MCU stall
module mcu_io_top_asserts import mcu_io_pkg::*; (
    input logic    sysclk,
    input logic    rst,
    input regbus_t bus,
    input av_cmd_t av_cmd,
    input logic    av_waitrequest,
    input logic    mcu_wait
);

    // bridge never issues both kinds of transfer at once
    a_no_rd_wr : assert property (
        @(posedge sysclk) disable iff (rst)
        !(av_cmd.read && av_cmd.write)
    ) else $error("avalon read and write asserted together");

    // back-pressure freezes the whole request
    a_cmd_stable : assert property (
        @(posedge sysclk) disable iff (rst)
        (av_cmd.read || av_cmd.write) && av_waitrequest |=> $stable(av_cmd)
    ) else $error("avalon request changed while waitrequest was high");

    // MCU held off from the cycle after a transfer strobe
    a_wait_cover : assert property (
        @(posedge sysclk) disable iff (rst)
        (bus.load[R_AV_WRITE_DATA] || bus.read[R_AV_WRITE_DATA]) |=> mcu_wait
    ) else $error("avalon transfer strobe did not stall the MCU");

endmodule

bind mcu_io_top mcu_io_top_asserts av_checks (
    .sysclk         (sysclk),
    .rst            (rst),
    .bus            (bus),
    .av_cmd         (av_cmd),
    .av_waitrequest (av_waitrequest),
    .mcu_wait       (mcu_wait)
);

//--- sim/mcu_io_top_tb.sv
`timescale 1ns/10ps

module mcu_io_top_tb import mcu_io_pkg::*; ;

    typedef enum logic [2:0] {OP_LOAD, OP_READ, OP_KEYS, OP_WIDLE, OP_WUART} op_kind_t;

    // one table row, the name travels in a parallel queue
    typedef struct packed {
        op_kind_t   kind;
        logic [3:0] idx;   // register index
        word_t      data;  // load data or key level
        word_t      exp;   // expected reg value, mcu_wait for OP_WIDLE, tx_line for OP_WUART
    } op_t;

    logic        sysclk;
    logic        rst;
    regbus_t     bus;
    reg_file_t   r;
    logic        mcu_wait;
    logic [1:0]  keys;
    byte_t       leds;
    logic        tx_line;
    logic        rx_line;
    av_cmd_t     av_cmd;
    logic        av_waitrequest;
    word_t       av_readdata;

    op_t         ops[$];
    string       names[$];
    logic [31:0] slave_addr[$];  // avalon slave storage, address and word pairs
    word_t       slave_data[$];
    int          checks;
    int          errors;
    logic        table_done;

    mcu_io_top DUT (
        .sysclk         (sysclk),
        .rst            (rst),
        .bus            (bus),
        .r              (r),
        .mcu_wait       (mcu_wait),
        .keys           (keys),
        .leds           (leds),
        .tx_line        (tx_line),
        .rx_line        (rx_line),
        .av_cmd         (av_cmd),
        .av_waitrequest (av_waitrequest),
        .av_readdata    (av_readdata)
    );

    assign rx_line = tx_line;  // uart loopback

    initial begin
        sysclk = 1'b0;
        forever #10 sysclk = ~sysclk;  // 20 ns period
    end

    task automatic add_op(input op_kind_t kind, input int idx, input word_t data,
                          input word_t exp, input string name);
        op_t op;
        op.kind = kind;
        op.idx  = idx[3:0];
        op.data = data;
        op.exp  = exp;
        ops.push_back(op);
        names.push_back(name);
    endtask

    task automatic check_value(input string name, input word_t exp, input word_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Fail %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    // index of a stored address, -1 when never written
    function automatic int slave_lookup(input logic [31:0] addr);
        for (int k = 0; k < slave_addr.size(); k++)
            if (slave_addr[k] == addr)
                return k;
        return -1;
    endfunction

    // avalon slave, random 0..5 wait states per request
    initial begin
        int    wait_left;
        logic  in_req;
        int    slot;
        wait_left      = 0;
        in_req         = 1'b0;
        av_waitrequest = 1'b0;
        av_readdata    = '0;
        void'($urandom(63735));  // single seed for the run
        forever begin
            @(negedge sysclk);
            if (rst || !(av_cmd.read || av_cmd.write)) begin
                av_waitrequest = 1'b0;
                in_req         = 1'b0;
            end else begin
                if (!in_req) begin
                    in_req    = 1'b1;
                    wait_left = $urandom % 6;
                end
                if (wait_left > 0) begin
                    av_waitrequest = 1'b1;
                    wait_left--;
                end else begin
                    av_waitrequest = 1'b0;  // accept at the coming edge
                    in_req         = 1'b0;
                    slot           = slave_lookup(av_cmd.address);
                    if (av_cmd.write) begin
                        if (slot < 0) begin
                            slave_addr.push_back(av_cmd.address);
                            slave_data.push_back(av_cmd.writedata);
                        end else begin
                            slave_data[slot] = av_cmd.writedata;
                        end
                    end else if (slot < 0) begin
                        // unwritten location, pattern from the whole address
                        av_readdata = av_cmd.address[31:16] ^ av_cmd.address[15:0];
                    end else begin
                        av_readdata = slave_data[slot];
                    end
                end
            end
        end
    end

    // watchdog, every row gets a uart frame plus margin
    initial begin
        int limit;
        wait (table_done);
        limit = ops.size() * (FRAME_BITS * SAMPLE_DIV * SAMPLES_PER_BIT + 40) + 8;
        repeat (limit) @(posedge sysclk);
        $display("timeout: the test table did not finish within %0d cycles", limit);
        $display("Something failed");
        $finish;
    end

    initial begin
        op_t op;
        int  errs_before;
        rst        = 1'b1;
        bus        = '0;
        keys       = 2'b11;  // nothing pressed
        checks     = 0;
        errors     = 0;
        table_done = 1'b0;

        // reset values
        for (int g = 0; g < NUM_GP; g++)
            add_op(OP_READ, g, 16'h0, 16'h0000, $sformatf("gp%0d_reset", g));
        add_op(OP_READ,  R_RSTK,          16'h0,    16'h0000, "rstk_reset");
        add_op(OP_READ,  R_LEDS,          16'h0,    16'h0000, "leds_reset");
        add_op(OP_READ,  R_KEYS,          16'h0,    16'h0000, "keys_reset");
        add_op(OP_READ,  R_ATX_CTRL,      16'h0,    16'h0000, "ctrl_reset");
        add_op(OP_READ,  R_AV_AD_HI,      16'h0,    16'h0000, "ad_hi_reset");
        add_op(OP_READ,  R_AV_READ_DATA,  16'h0,    16'h0000, "rdata_reset");
        // general purpose registers
        add_op(OP_LOAD,  0,               16'h1234, 16'h0,    "gp0_load");
        add_op(OP_LOAD,  1,               16'habcd, 16'h0,    "gp1_load");
        add_op(OP_LOAD,  2,               16'h0f0f, 16'h0,    "gp2_load");
        add_op(OP_LOAD,  3,               16'hffff, 16'h0,    "gp3_load");
        add_op(OP_READ,  0,               16'h0,    16'h1234, "gp0_value");
        add_op(OP_READ,  1,               16'h0,    16'habcd, "gp1_value");
        add_op(OP_READ,  2,               16'h0,    16'h0f0f, "gp2_value");
        add_op(OP_READ,  3,               16'h0,    16'hffff, "gp3_value");
        add_op(OP_LOAD,  2,               16'h5555, 16'h0,    "gp2_reload");
        add_op(OP_READ,  1,               16'h0,    16'habcd, "gp1_kept");
        add_op(OP_READ,  2,               16'h0,    16'h5555, "gp2_new");
        add_op(OP_READ,  3,               16'h0,    16'hffff, "gp3_kept");
        // return stack, reads pop
        add_op(OP_LOAD,  R_RSTK,          16'h1111, 16'h0,    "push_1");
        add_op(OP_LOAD,  R_RSTK,          16'h2222, 16'h0,    "push_2");
        add_op(OP_LOAD,  R_RSTK,          16'h3333, 16'h0,    "push_3");
        add_op(OP_READ,  R_RSTK,          16'h0,    16'h3333, "pop_3");
        add_op(OP_READ,  R_RSTK,          16'h0,    16'h2222, "pop_2");
        add_op(OP_READ,  R_RSTK,          16'h0,    16'h1111, "pop_1");
        add_op(OP_READ,  R_RSTK,          16'h0,    16'h0000, "stack_empty");
        // leds and keys
        add_op(OP_LOAD,  R_LEDS,          16'h005a, 16'h0,    "leds_load");
        add_op(OP_READ,  R_LEDS,          16'h0,    16'h005a, "leds_value");
        add_op(OP_KEYS,  0,               16'h0002, 16'h0,    "key0_press");
        add_op(OP_READ,  R_KEYS,          16'h0,    16'h0001, "key0_seen");
        add_op(OP_KEYS,  0,               16'h0000, 16'h0,    "keys_both");
        add_op(OP_READ,  R_KEYS,          16'h0,    16'h0003, "keys_both_seen");
        add_op(OP_KEYS,  0,               16'h0003, 16'h0,    "keys_release");
        add_op(OP_READ,  R_KEYS,          16'h0,    16'h0000, "keys_clear");
        // avalon writes to two addresses differing only in the high word
        add_op(OP_LOAD,  R_AV_AD_HI,      16'h0001, 16'h0,    "av_hi_a");
        add_op(OP_LOAD,  R_AV_AD_LO,      16'h0010, 16'h0,    "av_lo");
        add_op(OP_LOAD,  R_AV_WRITE_DATA, 16'hbeef, 16'h0,    "av_wr_a");
        add_op(OP_WIDLE, 0,               16'h0,    16'h0001, "av_wr_a_done");
        add_op(OP_LOAD,  R_AV_AD_HI,      16'h0002, 16'h0,    "av_hi_b");
        add_op(OP_LOAD,  R_AV_WRITE_DATA, 16'h1234, 16'h0,    "av_wr_b");
        add_op(OP_WIDLE, 0,               16'h0,    16'h0001, "av_wr_b_done");
        // avalon reads back
        add_op(OP_LOAD,  R_AV_AD_HI,      16'h0001, 16'h0,    "av_hi_a_again");
        add_op(OP_READ,  R_AV_WRITE_DATA, 16'h0,    16'h1234, "av_rd_a");
        add_op(OP_WIDLE, 0,               16'h0,    16'h0001, "av_rd_a_done");
        add_op(OP_READ,  R_AV_READ_DATA,  16'h0,    16'hbeef, "av_rd_a_data");
        add_op(OP_LOAD,  R_AV_AD_HI,      16'h0002, 16'h0,    "av_hi_b_again");
        add_op(OP_READ,  R_AV_WRITE_DATA, 16'h0,    16'h1234, "av_rd_b");
        add_op(OP_WIDLE, 0,               16'h0,    16'h0001, "av_rd_b_done");
        add_op(OP_READ,  R_AV_READ_DATA,  16'h0,    16'h1234, "av_rd_b_data");
        add_op(OP_LOAD,  R_AV_AD_HI,      16'h0003, 16'h0,    "av_hi_c");
        add_op(OP_READ,  R_AV_WRITE_DATA, 16'h0,    16'h1234, "av_rd_c");
        add_op(OP_WIDLE, 0,               16'h0,    16'h0001, "av_rd_c_done");
        add_op(OP_READ,  R_AV_READ_DATA,  16'h0,    16'h0013, "av_rd_c_fill");
        // uart loopback, go set then cleared
        add_op(OP_LOAD,  R_ATX_DATA,      16'h00a5, 16'h0,    "tx_byte_a");
        add_op(OP_LOAD,  R_ATX_CTRL,      16'h0001, 16'h0,    "go_set_a");
        add_op(OP_LOAD,  R_ATX_CTRL,      16'h0000, 16'h0,    "go_clear_a");
        add_op(OP_READ,  R_ATX_CTRL,      16'h0,    16'h0002, "tx_busy_a");
        add_op(OP_WUART, 0,               16'h0,    16'h0001, "uart_a_done");
        add_op(OP_READ,  R_ATX_DATA,      16'h0,    16'h00a5, "rx_byte_a");
        add_op(OP_READ,  R_ATX_CTRL,      16'h0,    16'h0000, "ctrl_idle_a");
        add_op(OP_LOAD,  R_ATX_DATA,      16'h003c, 16'h0,    "tx_byte_b");
        add_op(OP_LOAD,  R_ATX_CTRL,      16'h0001, 16'h0,    "go_set_b");
        add_op(OP_LOAD,  R_ATX_CTRL,      16'h0000, 16'h0,    "go_clear_b");
        add_op(OP_READ,  R_ATX_CTRL,      16'h0,    16'h0002, "tx_busy_b");
        add_op(OP_WUART, 0,               16'h0,    16'h0001, "uart_b_done");
        add_op(OP_READ,  R_ATX_DATA,      16'h0,    16'h003c, "rx_byte_b");
        table_done = 1'b1;

        repeat (8) @(negedge sysclk);
        rst = 1'b0;

        // every row starts and ends on a falling edge
        for (int i = 0; i < ops.size(); i++) begin
            op          = ops[i];
            errs_before = errors;
            case (op.kind)
                OP_LOAD: begin
                    while (mcu_wait) @(negedge sysclk);  // no strobes while stalled
                    bus.load[op.idx] = 1'b1;
                    bus.load_data    = op.data;
                    @(negedge sysclk);
                    bus = '0;
                end
                OP_READ: begin
                    while (mcu_wait) @(negedge sysclk);
                    check_value(names[i], op.exp, r[op.idx]);  // value seen as the read happens
                    if (op.idx == R_LEDS)
                        check_value(names[i], op.exp, {8'h00, leds});
                    bus.read[op.idx] = 1'b1;  // pops the stack or starts an avalon read
                    @(negedge sysclk);
                    bus = '0;
                end
                OP_KEYS: begin
                    keys = op.data[1:0];
                    @(negedge sysclk);
                end
                OP_WIDLE: begin
                    check_value(names[i], op.exp, {15'h0000, mcu_wait});  // transfer underway
                    while (mcu_wait) @(negedge sysclk);
                end
                OP_WUART: begin
                    while (r[R_ATX_CTRL][2:1] != 2'b00) @(negedge sysclk);  // rx and tx idle
                    check_value(names[i], op.exp, {15'h0000, tx_line});  // line back to idle
                end
                default: begin
                    errors++;
                    $display("table row %0d has an unknown operation kind", i);
                end
            endcase
            $display("%-16s %s", names[i], (errors == errs_before) ? "ok" : "failed");
        end

        $display("%0d tests, %0d checks, %0d errors", ops.size(), checks, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

//--- src.f
rtl/mcu_io_pkg.sv
rtl/std_reg.sv
rtl/stack_reg.sv
rtl/avalon_bridge.sv
rtl/uart_tx.sv
rtl/uart_rx.sv
rtl/mcu_io_top.sv
sim/mcu_io_top_asserts.sv
sim/mcu_io_top_tb.sv
